//--- bench/retire_trace_tb.sv
/*
 * Testbench for the retirement trace unit
 * Random pipeline events checked against a model of the trace record
 */
module retire_trace_tb import trace_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned OrderWidth = 64;
  localparam int IdleCycles    = 6;
  localparam int NumInsn       = 8;
  localparam int MaxInsnCycles = 5;
  localparam int RandCycles    = 300;
  localparam int IntrCycles    = 20;
  localparam int StimCycles    = IdleCycles + 3 * NumInsn * MaxInsnCycles + RandCycles
                                 + IntrCycles;
  localparam int TimeoutCycles = 2 * StimCycles + 100;

  logic        clk;
  logic        rst_ni;
  logic        instr_new_i, instr_ret_i, instr_is_compressed_i, illegal_insn_i;
  word_t       instr_rdata_i, pc_id_i, pc_if_i;
  half_t       instr_rdata_c_i;
  priv_lvl_e   priv_mode_i;
  reg_addr_t   rs1_addr_i, rs2_addr_i, rd_addr_i;
  word_t       rs1_data_i, rs2_data_i, rd_wdata_i;
  logic        rd_we_i, lsu_valid_i, data_we_i, pc_set_i;
  data_type_e  data_type_i;
  word_t       mem_addr_i, mem_rdata_i, mem_wdata_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;

  logic                  rvfi_valid_o, rvfi_trap_o, rvfi_halt_o, rvfi_intr_o;
  logic [OrderWidth-1:0] rvfi_order_o;
  priv_lvl_e             rvfi_mode_o;
  reg_addr_t             rvfi_rs1_addr_o, rvfi_rs2_addr_o, rvfi_rd_addr_o;
  word_t                 rvfi_insn_o, rvfi_rs1_rdata_o, rvfi_rs2_rdata_o, rvfi_rd_wdata_o;
  word_t                 rvfi_pc_rdata_o, rvfi_pc_wdata_o, rvfi_mem_addr_o;
  word_t                 rvfi_mem_rdata_o, rvfi_mem_wdata_o;
  byte_mask_t            rvfi_mem_rmask_o, rvfi_mem_wmask_o;

  // Model of the held state
  logic      m_open, m_trap;
  word_t     m_rs1, m_rs2, m_rd_wdata, m_mem_addr, m_mem_rdata, m_mem_wdata;
  reg_addr_t m_rd_addr;

  // Expected record after the next rising edge
  logic                  e_valid, e_trap, e_intr;
  logic [OrderWidth-1:0] e_order;
  logic [1:0]            e_mode;
  reg_addr_t             e_rs1_addr, e_rs2_addr, e_rd_addr;
  word_t                 e_insn, e_rs1_rdata, e_rs2_rdata, e_rd_wdata, e_pc_rdata, e_pc_wdata;
  word_t                 e_mem_addr, e_mem_rdata, e_mem_wdata;
  byte_mask_t            e_rmask, e_wmask;

  integer seed = 95509;
  int     errors = 0;
  int     test_errors = 0;
  int     test_num = 0;
  int     tests_failed = 0;
  int     cycle_count = 0;
  logic   checking = 1'b0;

  retire_trace #(.OrderWidth(OrderWidth)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic void advance_model();
    logic       open;
    logic       trap_entry;
    byte_mask_t mask;
    open       = instr_new_i | m_open;
    trap_entry = pc_set_i && (pc_mux_i == PC_EXC) &&
                 (exc_pc_mux_i == EXC_PC_EXC || exc_pc_mux_i == EXC_PC_IRQ);
    case (data_type_i)
      TYPE_WORD: mask = 4'b1111;
      TYPE_HALF: mask = 4'b0011;
      TYPE_BYTE: mask = 4'b0001;
      default:   mask = 4'b0000;
    endcase
    if (instr_new_i) begin
      m_rs1 = rs1_data_i;
      m_rs2 = rs2_data_i;
    end
    if (open) begin
      m_rd_addr  = rd_we_i ? rd_addr_i : 5'd0;
      m_rd_wdata = (rd_we_i && rd_addr_i != 5'd0) ? rd_wdata_i : 32'd0;
    end
    if (open && lsu_valid_i) begin
      m_mem_addr  = mem_addr_i;
      m_mem_rdata = mem_rdata_i;
      m_mem_wdata = mem_wdata_i;
    end
    // Order counts the records reported before this one
    e_order     = e_order + OrderWidth'(e_valid);
    e_valid     = instr_ret_i;
    e_insn      = instr_is_compressed_i ? {16'h0000, instr_rdata_c_i} : instr_rdata_i;
    e_trap      = illegal_insn_i;
    e_intr      = m_trap & open;
    e_mode      = priv_mode_i;
    e_rs1_addr  = rs1_addr_i;
    e_rs2_addr  = rs2_addr_i;
    e_rs1_rdata = m_rs1;
    e_rs2_rdata = m_rs2;
    e_rd_addr   = m_rd_addr;
    e_rd_wdata  = m_rd_wdata;
    e_pc_rdata  = pc_id_i;
    e_pc_wdata  = pc_if_i;
    e_mem_addr  = m_mem_addr;
    e_mem_rdata = m_mem_rdata;
    e_mem_wdata = m_mem_wdata;
    e_rmask     = mask;
    e_wmask     = data_we_i ? mask : 4'b0000;
    m_open      = instr_ret_i ? 1'b0 : open;
    if (trap_entry) begin
      m_trap = 1'b1;
    end else if (instr_ret_i) begin
      m_trap = 1'b0;
    end
  endfunction

  task automatic reset_model();
    {m_open, m_trap, m_rs1, m_rs2, m_rd_addr, m_rd_wdata} = '0;
    {m_mem_addr, m_mem_rdata, m_mem_wdata} = '0;
    {e_valid, e_trap, e_intr, e_order, e_insn, e_rs1_addr, e_rs2_addr} = '0;
    {e_rs1_rdata, e_rs2_rdata, e_rd_addr, e_rd_wdata, e_pc_rdata, e_pc_wdata} = '0;
    {e_mem_addr, e_mem_rdata, e_mem_wdata, e_rmask, e_wmask} = '0;
    e_mode = PRIV_LVL_M;
  endtask

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic compare_record();
    compare_field("rvfi_valid_o", rvfi_valid_o, e_valid);
    compare_field("rvfi_order_o", rvfi_order_o, e_order);
    compare_field("rvfi_insn_o", rvfi_insn_o, e_insn);
    compare_field("rvfi_trap_o", rvfi_trap_o, e_trap);
    compare_field("rvfi_halt_o", rvfi_halt_o, 1'b0);
    compare_field("rvfi_intr_o", rvfi_intr_o, e_intr);
    compare_field("rvfi_mode_o", rvfi_mode_o, e_mode);
    compare_field("rvfi_rs1_addr_o", rvfi_rs1_addr_o, e_rs1_addr);
    compare_field("rvfi_rs2_addr_o", rvfi_rs2_addr_o, e_rs2_addr);
    compare_field("rvfi_rs1_rdata_o", rvfi_rs1_rdata_o, e_rs1_rdata);
    compare_field("rvfi_rs2_rdata_o", rvfi_rs2_rdata_o, e_rs2_rdata);
    compare_field("rvfi_rd_addr_o", rvfi_rd_addr_o, e_rd_addr);
    compare_field("rvfi_rd_wdata_o", rvfi_rd_wdata_o, e_rd_wdata);
    compare_field("rvfi_pc_rdata_o", rvfi_pc_rdata_o, e_pc_rdata);
    compare_field("rvfi_pc_wdata_o", rvfi_pc_wdata_o, e_pc_wdata);
    compare_field("rvfi_mem_addr_o", rvfi_mem_addr_o, e_mem_addr);
    compare_field("rvfi_mem_rmask_o", rvfi_mem_rmask_o, e_rmask);
    compare_field("rvfi_mem_wmask_o", rvfi_mem_wmask_o, e_wmask);
    compare_field("rvfi_mem_rdata_o", rvfi_mem_rdata_o, e_mem_rdata);
    compare_field("rvfi_mem_wdata_o", rvfi_mem_wdata_o, e_mem_wdata);
  endtask

  // Outputs settle shortly after the rising edge
  initial begin
    forever begin
      @(posedge clk);
      #2;
      if (checking) begin
        compare_record();
      end
    end
  end

  initial begin
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: no end of test within %0d cycles", TimeoutCycles);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic randomize_data();
    instr_rdata_i         = rand_word();
    instr_rdata_c_i       = 16'(rand_word());
    instr_is_compressed_i = 1'(rand_word());
    illegal_insn_i        = (rand_word() % 8) == 0;
    case (rand_word() % 3)
      0:       priv_mode_i = PRIV_LVL_U;
      1:       priv_mode_i = PRIV_LVL_S;
      default: priv_mode_i = PRIV_LVL_M;
    endcase
    pc_id_i      = rand_word();
    pc_if_i      = rand_word();
    rs1_addr_i   = 5'(rand_word());
    rs2_addr_i   = 5'(rand_word());
    rs1_data_i   = rand_word();
    rs2_data_i   = rand_word();
    rd_we_i      = 1'(rand_word());
    // x0 comes up often enough to matter
    rd_addr_i    = (rand_word() % 4 == 0) ? 5'd0 : 5'(rand_word());
    rd_wdata_i   = rand_word();
    data_we_i    = 1'(rand_word());
    data_type_i  = data_type_e'(2'(rand_word()));
    mem_addr_i   = rand_word();
    mem_rdata_i  = rand_word();
    mem_wdata_i  = rand_word();
    pc_mux_i     = pc_sel_e'(3'(rand_word() % 5));
    exc_pc_mux_i = exc_pc_sel_e'(2'(rand_word()));
  endtask

  task automatic drive_cycle(input logic new_s, input logic ret_s, input logic lsu_s,
                             input logic set_s);
    @(negedge clk);
    randomize_data();
    instr_new_i = new_s;
    instr_ret_i = ret_s;
    lsu_valid_i = lsu_s;
    pc_set_i    = set_s;
    advance_model();
  endtask

  task automatic redirect_to_trap(input exc_pc_sel_e src);
    @(negedge clk);
    randomize_data();
    {instr_new_i, instr_ret_i, lsu_valid_i} = 3'b000;
    pc_set_i     = 1'b1;
    pc_mux_i     = PC_EXC;
    exc_pc_mux_i = src;
    advance_model();
  endtask

  // Decode, up to two middle cycles, retire, optional idle gap
  task automatic run_insn(input logic with_mem, input logic with_gap);
    int middle;
    middle = rand_word() % 3;
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    repeat (middle) drive_cycle(1'b0, 1'b0, with_mem & 1'(rand_word()), 1'b0);
    drive_cycle(1'b0, 1'b1, with_mem & 1'(rand_word()), 1'b0);
    if (with_gap) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic wait_record();
    @(posedge clk);
    #2;
    while (!rvfi_valid_o) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      @(posedge clk);
      #2;
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    @(posedge clk);
    #3;
    n = errors - test_errors;
    test_num++;
    if (n != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %s, %0d errors", test_num, name, (n == 0) ? "ok" : "FAILED", n);
    test_errors = errors;
  endtask

  task automatic trap_entry_test(input exc_pc_sel_e src);
    redirect_to_trap(src);
    run_insn(1'b0, 1'b0);
    wait_record();
    compare_field("rvfi_intr_o", rvfi_intr_o, 1'b1);
    run_insn(1'b0, 1'b0);
    wait_record();
    compare_field("rvfi_intr_o", rvfi_intr_o, 1'b0);
  endtask

  initial begin
    {instr_new_i, instr_ret_i, instr_is_compressed_i, illegal_insn_i} = 4'b0000;
    {instr_rdata_i, instr_rdata_c_i, pc_id_i, pc_if_i} = '0;
    {rs1_addr_i, rs2_addr_i, rs1_data_i, rs2_data_i} = '0;
    {rd_we_i, rd_addr_i, rd_wdata_i, lsu_valid_i, data_we_i, pc_set_i} = '0;
    {mem_addr_i, mem_rdata_i, mem_wdata_i} = '0;
    priv_mode_i  = PRIV_LVL_M;
    data_type_i  = TYPE_WORD;
    pc_mux_i     = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    rst_ni       = 1'b0;
    reset_model();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;
    compare_record();
    advance_model();
    checking = 1'b1;

    repeat (IdleCycles) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    finish_test("reset state");
    repeat (NumInsn) run_insn(1'b0, 1'b0);
    finish_test("retirement record");
    repeat (NumInsn) run_insn(1'b0, 1'b1);
    finish_test("register capture");
    repeat (NumInsn) run_insn(1'b1, 1'b1);
    finish_test("memory capture");
    repeat (RandCycles) begin
      drive_cycle(rand_word() % 4 == 0, rand_word() % 4 == 0, rand_word() % 3 == 0,
                  rand_word() % 8 == 0);
    end
    finish_test("order counter");
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    trap_entry_test(EXC_PC_EXC);
    trap_entry_test(EXC_PC_IRQ);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    finish_test("interrupt flag");

    $display("Tests %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- list.f
logic/trace_pkg.sv
logic/operand_capture.sv
logic/mem_capture.sv
logic/trap_tracker.sv
logic/retire_register.sv
logic/retire_trace.sv
bench/retire_trace_tb.sv

//--- logic/mem_capture.sv
/*
 * Memory access capture
 * Byte mask from the access size, address and data of the open instruction
 */
module mem_capture import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_ni,
  input  logic       insn_new_i,
  input  logic       lsu_valid_i,
  input  data_type_e data_type_i,
  input  word_t      mem_addr_i,
  input  word_t      mem_rdata_i,
  input  word_t      mem_wdata_i,
  output byte_mask_t mem_mask_o,
  output word_t      mem_addr_o,
  output word_t      mem_rdata_o,
  output word_t      mem_wdata_o
);

  logic  mem_load;
  word_t mem_addr_q;
  word_t mem_rdata_q;
  word_t mem_wdata_q;

  // Lanes from the low end of the word
  always_comb begin
    case (data_type_i)
      TYPE_WORD: mem_mask_o = 4'b1111;
      TYPE_HALF: mem_mask_o = 4'b0011;
      TYPE_BYTE: mem_mask_o = 4'b0001;
      default:   mem_mask_o = 4'b0000;
    endcase
  end

  // Completing access of the current instruction
  assign mem_load = insn_new_i & lsu_valid_i;

  assign mem_addr_o  = mem_load ? mem_addr_i  : mem_addr_q;
  assign mem_rdata_o = mem_load ? mem_rdata_i : mem_rdata_q;
  assign mem_wdata_o = mem_load ? mem_wdata_i : mem_wdata_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_addr_q  <= '0;
      mem_rdata_q <= '0;
      mem_wdata_q <= '0;
    end else begin
      mem_addr_q  <= mem_addr_o;
      mem_rdata_q <= mem_rdata_o;
      mem_wdata_q <= mem_wdata_o;
    end
  end

endmodule

//--- logic/operand_capture.sv
/*
 * Operand capture
 * Selects the instruction word, tracks the open instruction and holds
 * its source and destination register values
 */
module operand_capture import trace_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  logic      instr_new_i,
  input  logic      instr_ret_i,
  input  word_t     instr_rdata_i,
  input  half_t     instr_rdata_c_i,
  input  logic      instr_is_compressed_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  logic      rd_we_i,
  input  reg_addr_t rd_addr_i,
  input  word_t     rd_wdata_i,
  output word_t     insn_o,
  output logic      insn_new_o,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o,
  output reg_addr_t rd_addr_o,
  output word_t     rd_wdata_o
);

  logic      insn_new_q;
  word_t     rs1_data_q;
  word_t     rs2_data_q;
  reg_addr_t rd_addr_q;
  word_t     rd_wdata_q;

  // Compressed encodings are reported zero-extended
  assign insn_o = instr_is_compressed_i ? {16'h0000, instr_rdata_c_i} : instr_rdata_i;

  ////////////////////////////////////////
  // Open instruction flag
  ////////////////////////////////////////

  assign insn_new_o = instr_new_i | insn_new_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_new_q <= 1'b0;
    end else if (instr_ret_i) begin
      insn_new_q <= 1'b0;
    end else begin
      insn_new_q <= insn_new_o;
    end
  end

  ////////////////////////////////////////
  // Register values
  ////////////////////////////////////////

  // Sources are read in decode
  assign rs1_data_o = instr_new_i ? rs1_data_i : rs1_data_q;
  assign rs2_data_o = instr_new_i ? rs2_data_i : rs2_data_q;

  // Destination follows the write port while the instruction is open
  always_comb begin
    rd_addr_o  = rd_addr_q;
    rd_wdata_o = rd_wdata_q;
    if (insn_new_o) begin
      if (!rd_we_i) begin
        rd_addr_o  = '0;
        rd_wdata_o = '0;
      end else begin
        rd_addr_o = rd_addr_i;
        // x0 is hardwired to zero
        rd_wdata_o = (rd_addr_i == 5'd0) ? '0 : rd_wdata_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_data_q <= '0;
      rs2_data_q <= '0;
      rd_addr_q  <= '0;
      rd_wdata_q <= '0;
    end else begin
      rs1_data_q <= rs1_data_o;
      rs2_data_q <= rs2_data_o;
      rd_addr_q  <= rd_addr_o;
      rd_wdata_q <= rd_wdata_o;
    end
  end

endmodule

//--- logic/retire_register.sv
/*
 * Trace record register
 * Samples the record every cycle and counts reported retirements
 */
module retire_register import trace_pkg::*; #(
  parameter int unsigned OrderWidth = 64
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  instr_ret_i,
  input  logic                  illegal_insn_i,
  input  logic                  intr_i,
  input  priv_lvl_e             priv_mode_i,
  input  word_t                 insn_i,
  input  reg_addr_t             rs1_addr_i,
  input  reg_addr_t             rs2_addr_i,
  input  word_t                 rs1_data_i,
  input  word_t                 rs2_data_i,
  input  reg_addr_t             rd_addr_i,
  input  word_t                 rd_wdata_i,
  input  word_t                 pc_id_i,
  input  word_t                 pc_if_i,
  input  logic                  data_we_i,
  input  byte_mask_t            mem_mask_i,
  input  word_t                 mem_addr_i,
  input  word_t                 mem_rdata_i,
  input  word_t                 mem_wdata_i,
  output logic                  rvfi_valid_o,
  output logic [OrderWidth-1:0] rvfi_order_o,
  output word_t                 rvfi_insn_o,
  output logic                  rvfi_trap_o,
  output logic                  rvfi_halt_o,
  output logic                  rvfi_intr_o,
  output priv_lvl_e             rvfi_mode_o,
  output reg_addr_t             rvfi_rs1_addr_o,
  output reg_addr_t             rvfi_rs2_addr_o,
  output word_t                 rvfi_rs1_rdata_o,
  output word_t                 rvfi_rs2_rdata_o,
  output reg_addr_t             rvfi_rd_addr_o,
  output word_t                 rvfi_rd_wdata_o,
  output word_t                 rvfi_pc_rdata_o,
  output word_t                 rvfi_pc_wdata_o,
  output word_t                 rvfi_mem_addr_o,
  output byte_mask_t            rvfi_mem_rmask_o,
  output byte_mask_t            rvfi_mem_wmask_o,
  output word_t                 rvfi_mem_rdata_o,
  output word_t                 rvfi_mem_wdata_o
);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o     <= 1'b0;
      rvfi_order_o     <= '0;
      rvfi_insn_o      <= '0;
      rvfi_trap_o      <= 1'b0;
      rvfi_halt_o      <= 1'b0;
      rvfi_intr_o      <= 1'b0;
      rvfi_mode_o      <= PRIV_RESET;
      rvfi_rs1_addr_o  <= '0;
      rvfi_rs2_addr_o  <= '0;
      rvfi_rs1_rdata_o <= '0;
      rvfi_rs2_rdata_o <= '0;
      rvfi_rd_addr_o   <= '0;
      rvfi_rd_wdata_o  <= '0;
      rvfi_pc_rdata_o  <= '0;
      rvfi_pc_wdata_o  <= '0;
      rvfi_mem_addr_o  <= '0;
      rvfi_mem_rmask_o <= '0;
      rvfi_mem_wmask_o <= '0;
      rvfi_mem_rdata_o <= '0;
      rvfi_mem_wdata_o <= '0;
    end else begin
      rvfi_valid_o     <= instr_ret_i;
      // Counts the records already reported
      rvfi_order_o     <= rvfi_order_o + OrderWidth'(rvfi_valid_o);
      rvfi_insn_o      <= insn_i;
      rvfi_trap_o      <= illegal_insn_i;
      rvfi_halt_o      <= 1'b0;
      rvfi_intr_o      <= intr_i;
      rvfi_mode_o      <= priv_mode_i;
      rvfi_rs1_addr_o  <= rs1_addr_i;
      rvfi_rs2_addr_o  <= rs2_addr_i;
      rvfi_rs1_rdata_o <= rs1_data_i;
      rvfi_rs2_rdata_o <= rs2_data_i;
      rvfi_rd_addr_o   <= rd_addr_i;
      rvfi_rd_wdata_o  <= rd_wdata_i;
      // PC of the retiring instruction and the one after it
      rvfi_pc_rdata_o  <= pc_id_i;
      rvfi_pc_wdata_o  <= pc_if_i;
      rvfi_mem_addr_o  <= mem_addr_i;
      rvfi_mem_rmask_o <= mem_mask_i;
      // Only stores write
      rvfi_mem_wmask_o <= data_we_i ? mem_mask_i : 4'b0000;
      rvfi_mem_rdata_o <= mem_rdata_i;
      rvfi_mem_wdata_o <= mem_wdata_i;
    end
  end

endmodule

//--- logic/retire_trace.sv
/*
 * Retirement trace unit
 * Watches pipeline events and reports one record per retired instruction
 */
module retire_trace import trace_pkg::*; #(
  parameter int unsigned OrderWidth = 64
) (
  input  logic                  clk,
  input  logic                  rst_ni,

  // Decode and retirement
  input  logic                  instr_new_i,
  input  logic                  instr_ret_i,
  input  word_t                 instr_rdata_i,
  input  half_t                 instr_rdata_c_i,
  input  logic                  instr_is_compressed_i,
  input  logic                  illegal_insn_i,
  input  priv_lvl_e             priv_mode_i,
  input  word_t                 pc_id_i,
  input  word_t                 pc_if_i,

  // Register file
  input  reg_addr_t             rs1_addr_i,
  input  reg_addr_t             rs2_addr_i,
  input  word_t                 rs1_data_i,
  input  word_t                 rs2_data_i,
  input  logic                  rd_we_i,
  input  reg_addr_t             rd_addr_i,
  input  word_t                 rd_wdata_i,

  // Load/store unit
  input  logic                  lsu_valid_i,
  input  logic                  data_we_i,
  input  data_type_e            data_type_i,
  input  word_t                 mem_addr_i,
  input  word_t                 mem_rdata_i,
  input  word_t                 mem_wdata_i,

  // PC redirect
  input  logic                  pc_set_i,
  input  pc_sel_e               pc_mux_i,
  input  exc_pc_sel_e           exc_pc_mux_i,

  // Trace record
  output logic                  rvfi_valid_o,
  output logic [OrderWidth-1:0] rvfi_order_o,
  output word_t                 rvfi_insn_o,
  output logic                  rvfi_trap_o,
  output logic                  rvfi_halt_o,
  output logic                  rvfi_intr_o,
  output priv_lvl_e             rvfi_mode_o,
  output reg_addr_t             rvfi_rs1_addr_o,
  output reg_addr_t             rvfi_rs2_addr_o,
  output word_t                 rvfi_rs1_rdata_o,
  output word_t                 rvfi_rs2_rdata_o,
  output reg_addr_t             rvfi_rd_addr_o,
  output word_t                 rvfi_rd_wdata_o,
  output word_t                 rvfi_pc_rdata_o,
  output word_t                 rvfi_pc_wdata_o,
  output word_t                 rvfi_mem_addr_o,
  output byte_mask_t            rvfi_mem_rmask_o,
  output byte_mask_t            rvfi_mem_wmask_o,
  output word_t                 rvfi_mem_rdata_o,
  output word_t                 rvfi_mem_wdata_o
);

  // Open instruction flag that stays high in the retiring cycle
  logic       insn_new_hold;
  word_t      insn;
  word_t      rs1_data;
  word_t      rs2_data;
  reg_addr_t  rd_addr;
  word_t      rd_wdata;
  byte_mask_t mem_mask;
  word_t      mem_addr;
  word_t      mem_rdata;
  word_t      mem_wdata;
  logic       intr;

  ////////////////////////////////////////
  // Per-instruction capture
  ////////////////////////////////////////

  operand_capture u_operand_capture (
    .clk,
    .rst_ni,
    .instr_new_i,
    .instr_ret_i,
    .instr_rdata_i,
    .instr_rdata_c_i,
    .instr_is_compressed_i,
    .rs1_data_i,
    .rs2_data_i,
    .rd_we_i,
    .rd_addr_i,
    .rd_wdata_i,
    .insn_o       (insn),
    .insn_new_o   (insn_new_hold),
    .rs1_data_o   (rs1_data),
    .rs2_data_o   (rs2_data),
    .rd_addr_o    (rd_addr),
    .rd_wdata_o   (rd_wdata)
  );

  mem_capture u_mem_capture (
    .clk,
    .rst_ni,
    .insn_new_i   (insn_new_hold),
    .lsu_valid_i,
    .data_type_i,
    .mem_addr_i,
    .mem_rdata_i,
    .mem_wdata_i,
    .mem_mask_o   (mem_mask),
    .mem_addr_o   (mem_addr),
    .mem_rdata_o  (mem_rdata),
    .mem_wdata_o  (mem_wdata)
  );

  trap_tracker u_trap_tracker (
    .clk,
    .rst_ni,
    .pc_set_i,
    .pc_mux_i,
    .exc_pc_mux_i,
    .instr_ret_i,
    .insn_new_i   (insn_new_hold),
    .intr_o       (intr)
  );

  ////////////////////////////////////////
  // Record output
  ////////////////////////////////////////

  retire_register #(
    .OrderWidth (OrderWidth)
  ) u_retire_register (
    .clk,
    .rst_ni,
    .instr_ret_i,
    .illegal_insn_i,
    .intr_i       (intr),
    .priv_mode_i,
    .insn_i       (insn),
    .rs1_addr_i,
    .rs2_addr_i,
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rd_addr_i    (rd_addr),
    .rd_wdata_i   (rd_wdata),
    .pc_id_i,
    .pc_if_i,
    .data_we_i,
    .mem_mask_i   (mem_mask),
    .mem_addr_i   (mem_addr),
    .mem_rdata_i  (mem_rdata),
    .mem_wdata_i  (mem_wdata),
    .rvfi_valid_o,
    .rvfi_order_o,
    .rvfi_insn_o,
    .rvfi_trap_o,
    .rvfi_halt_o,
    .rvfi_intr_o,
    .rvfi_mode_o,
    .rvfi_rs1_addr_o,
    .rvfi_rs2_addr_o,
    .rvfi_rs1_rdata_o,
    .rvfi_rs2_rdata_o,
    .rvfi_rd_addr_o,
    .rvfi_rd_wdata_o,
    .rvfi_pc_rdata_o,
    .rvfi_pc_wdata_o,
    .rvfi_mem_addr_o,
    .rvfi_mem_rmask_o,
    .rvfi_mem_wmask_o,
    .rvfi_mem_rdata_o,
    .rvfi_mem_wdata_o
  );

endmodule

//--- logic/trace_pkg.sv
/*
 * Retirement trace definitions
 * Widths, pipeline encodings and the privilege mode shown after reset
 */
package trace_pkg;

  ////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////

  // Data, address, PC or instruction value
  typedef logic [31:0] word_t;

  // Compressed instruction
  typedef logic [15:0] half_t;

  // Register file index
  typedef logic [4:0] reg_addr_t;

  // One bit per byte lane
  typedef logic [3:0] byte_mask_t;

  ////////////////////////////////////////
  // Pipeline encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Access size with code 3 reserved
  typedef enum logic [1:0] {
    TYPE_WORD = 2'b00,
    TYPE_HALF = 2'b01,
    TYPE_BYTE = 2'b10
  } data_type_e;

  // Next PC source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // Exception PC source
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // Core comes out of reset in machine mode
  localparam priv_lvl_e PRIV_RESET = PRIV_LVL_M;

endpackage

//--- logic/trap_tracker.sv
/*
 * Trap entry tracker
 * Flags the first instruction completed after a jump into a trap handler
 */
module trap_tracker import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst_ni,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  logic        instr_ret_i,
  input  logic        insn_new_i,
  output logic        intr_o
);

  logic trap_pc_d;
  logic trap_pc_q;
  logic trap_entry;

  // Redirect to the exception or interrupt vector
  assign trap_entry = pc_set_i && (pc_mux_i == PC_EXC) &&
                      ((exc_pc_mux_i == EXC_PC_EXC) || (exc_pc_mux_i == EXC_PC_IRQ));

  always_comb begin
    trap_pc_d = trap_pc_q;
    if (trap_entry) begin
      trap_pc_d = 1'b1;
    end else if (trap_pc_q && instr_ret_i) begin
      // Handler's first instruction is done
      trap_pc_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_pc_q <= 1'b0;
    end else begin
      trap_pc_q <= trap_pc_d;
    end
  end

  assign intr_o = trap_pc_q & insn_new_i;

endmodule
